//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_genesis_mbus
DUT_TOP   = genesis_mbus
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- design/clk_enable_gen.sv
// --------------------
// CPU clock enable
// One-cycle enable pulse every 7, 4 or 2 master cycles,
// rate picked up at each pulse
// --------------------
`include "mbus_consts.svh"

module clk_enable_gen (
	input  logic             MCLK,
	input  logic             reset,
	input  mbus_pkg::turbo_t turbo,
	output logic             cpu_ce
);
	import mbus_pkg::*;

	logic [2:0] div_sel;
	logic [2:0] div_q;
	logic [2:0] cnt;

	always_comb begin
		case (turbo)
			TURBO_1: div_sel = `CE_DIV_TURBO1;
			TURBO_2: div_sel = `CE_DIV_TURBO2;
			default: div_sel = `CE_DIV_NORMAL;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cnt    <= 3'd0;
			cpu_ce <= 1'b1;
			div_q  <= div_sel;
		end else begin
			// New rate latched in the pulse cycle
			if (cpu_ce)
				div_q <= div_sel;
			if (cnt == div_q - 3'd1) begin
				cnt    <= 3'd0;
				cpu_ce <= 1'b1;
			end else begin
				cnt    <= cnt + 3'd1;
				cpu_ce <= 1'b0;
			end
		end
	end
endmodule

//--- design/genesis_mbus.sv
// --------------------
// Main-bus top level
// CPU enable divider, arbiter, work RAM and system
// registers joined on one shared main bus
// --------------------
`include "mbus_consts.svh"

module genesis_mbus (
	input  logic                MCLK,
	input  logic                reset,
	input  mbus_pkg::turbo_t    turbo,
	output logic                cpu_ce,
	input  logic                m68k_req,
	input  logic [`MBUS_AW-1:0] m68k_addr,
	input  logic [`MBUS_DW-1:0] m68k_wdata,
	input  logic                m68k_rnw,
	input  logic [1:0]          m68k_be,
	output logic [`MBUS_DW-1:0] m68k_rdata,
	output logic                m68k_ack,
	input  logic                z80_req,
	input  logic [`Z80_AW-1:0]  z80_addr,
	input  logic [7:0]          z80_wdata,
	input  logic                z80_rnw,
	output logic [7:0]          z80_rdata,
	output logic                z80_ack,
	input  logic [`MBUS_AW-1:0] rom_size,
	output logic [`MBUS_AW-1:0] rom_addr,
	output logic                rom_req,
	input  logic                rom_ack,
	input  logic [`MBUS_DW-1:0] rom_data,
	output logic                z80_busreq_n,
	output logic                z80_reset_n
);
	mbus_if bus ();

	clk_enable_gen ce_i (
		.MCLK(MCLK), .reset(reset), .turbo(turbo), .cpu_ce(cpu_ce)
	);

	mbus_arbiter arb_i (
		.MCLK(MCLK), .reset(reset), .cpu_ce(cpu_ce),
		.m68k_req(m68k_req), .m68k_addr(m68k_addr), .m68k_wdata(m68k_wdata),
		.m68k_rnw(m68k_rnw), .m68k_be(m68k_be), .m68k_rdata(m68k_rdata),
		.m68k_ack(m68k_ack),
		.z80_req(z80_req), .z80_addr(z80_addr), .z80_wdata(z80_wdata),
		.z80_rnw(z80_rnw), .z80_rdata(z80_rdata), .z80_ack(z80_ack),
		.rom_size(rom_size), .rom_req(rom_req), .rom_ack(rom_ack), .rom_data(rom_data),
		.bus(bus.arbiter)
	);

	work_ram wram_i (.MCLK(MCLK), .bus(bus.target));

	sys_regs regs_i (
		.MCLK(MCLK), .reset(reset), .rom_size(rom_size),
		.z80_busreq_n(z80_busreq_n), .z80_reset_n(z80_reset_n),
		.bus(bus.target)
	);

	// Mapped ROM address, stable while the request is out
	assign rom_addr = bus.rom_map_addr;
endmodule

//--- design/mbus_arbiter.sv
// --------------------
// Main-bus arbiter
// Accepts 68000 and Z80 requests, decodes the address,
// sequences work RAM, registers and the ROM handshake,
// and holds data and acknowledge until the request drops
// --------------------
`include "mbus_consts.svh"

module mbus_arbiter (
	input  logic                MCLK,
	input  logic                reset,
	input  logic                cpu_ce,
	input  logic                m68k_req,
	input  logic [`MBUS_AW-1:0] m68k_addr,
	input  logic [`MBUS_DW-1:0] m68k_wdata,
	input  logic                m68k_rnw,
	input  logic [1:0]          m68k_be,
	output logic [`MBUS_DW-1:0] m68k_rdata,
	output logic                m68k_ack,
	input  logic                z80_req,
	input  logic [`Z80_AW-1:0]  z80_addr,
	input  logic [7:0]          z80_wdata,
	input  logic                z80_rnw,
	output logic [7:0]          z80_rdata,
	output logic                z80_ack,
	input  logic [`MBUS_AW-1:0] rom_size,
	output logic                rom_req,
	input  logic                rom_ack,
	input  logic [`MBUS_DW-1:0] rom_data,
	mbus_if.arbiter             bus
);
	import mbus_pkg::*;

	mbus_state_t state;
	mbus_src_t src;
	logic z80_local;
	logic z80_bank_wr;
	logic z80_lo;
	logic [`MBUS_DW-1:0] data;
	logic take_m68k;
	logic take_z80;
	logic local_acc;
	logic rom_region;
	logic ram_region;
	logic rom_hit;
	logic src_req;

	// 68000 only on an enable cycle, and it wins a tie
	assign take_m68k = (state == ST_IDLE) && m68k_req && cpu_ce;
	assign take_z80  = (state == ST_IDLE) && z80_req && !take_m68k;

	// --------------------
	// Address decode
	// --------------------
	assign local_acc  = (src == SRC_Z80) && z80_local;
	assign rom_region = bus.addr[22:19] < `ROM_MAX_TOP;
	assign ram_region = &bus.addr[22:20];
	assign rom_hit    = rom_region && bus.rnw && (bus.addr < rom_size);

	assign bus.ram_sel      = (state == ST_SELECT) && !local_acc && ram_region;
	assign bus.reg_sel      = (state == ST_SELECT) && !local_acc && !rom_region && !ram_region;
	assign bus.z80_bank_we  = (state == ST_Z80_BANK) && z80_bank_wr;
	assign bus.z80_bank_bit = bus.wdata[0];

	assign m68k_ack   = (state == ST_FINISH) && (src == SRC_M68K);
	assign z80_ack    = (state == ST_FINISH) && (src == SRC_Z80);
	assign m68k_rdata = data;
	// Even Z80 address reads the upper lane
	assign z80_rdata  = z80_lo ? data[7:0] : data[15:8];
	assign src_req    = (src == SRC_M68K) ? m68k_req : z80_req;

	// --------------------
	// State machine
	// --------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state   <= ST_IDLE;
			src     <= SRC_NONE;
			rom_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (take_m68k) begin
						src   <= SRC_M68K;
						state <= ST_SELECT;
					end else if (take_z80) begin
						src   <= SRC_Z80;
						state <= ST_SELECT;
					end
				end
				ST_SELECT: begin
					if (local_acc) begin
						state <= ST_Z80_BANK;
					end else if (rom_hit) begin
						rom_req <= ~rom_req;
						state   <= ST_ROM_READ;
					end else if (ram_region) begin
						state <= ST_RAM_READ;
					end else begin
						state <= ST_REG_READ;
					end
				end
				ST_RAM_READ, ST_REG_READ, ST_Z80_BANK:
					state <= ST_FINISH;
				ST_ROM_READ:
					if (rom_ack == rom_req)
						state <= ST_FINISH;
				ST_FINISH: begin
					// Held here until the requester lets go
					if (!src_req) begin
						src   <= SRC_NONE;
						state <= ST_IDLE;
					end
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Request fields and returned data
	always_ff @(posedge MCLK) begin
		if (take_m68k) begin
			bus.addr    <= m68k_addr;
			bus.wdata   <= m68k_wdata;
			bus.rnw     <= m68k_rnw;
			bus.uds_n   <= ~m68k_be[1];
			bus.lds_n   <= ~m68k_be[0];
			z80_local   <= 1'b0;
			z80_bank_wr <= 1'b0;
			z80_lo      <= 1'b0;
		end else if (take_z80) begin
			// Banked window at 8000-FFFF
			bus.addr    <= {bus.bar, z80_addr[14:1]};
			bus.wdata   <= {z80_wdata, z80_wdata};
			bus.rnw     <= z80_rnw;
			bus.uds_n   <= z80_addr[0];
			bus.lds_n   <= ~z80_addr[0];
			z80_local   <= ~z80_addr[15];
			z80_bank_wr <= ~z80_rnw && (z80_addr[15:8] == `Z80_BANK_PAGE);
			z80_lo      <= z80_addr[0];
		end
		case (state)
			ST_SELECT:
				if (local_acc)
					data <= '1;
			ST_RAM_READ:
				data <= bus.ram_q;
			ST_REG_READ:
				data <= bus.reg_q;
			ST_ROM_READ:
				if (rom_ack == rom_req)
					data <= rom_data;
			default: ;
		endcase
	end
endmodule

//--- design/mbus_consts.svh
// --------------------
// Main-bus constants
// Widths, address regions, CPU enable divider counts
// and register pages shared by the main-bus blocks
// --------------------
`ifndef MBUS_CONSTS_SVH
`define MBUS_CONSTS_SVH

// Bus widths, main-bus addresses are word addresses
`define MBUS_AW 23
`define MBUS_DW 16
`define WRAM_AW 15
`define Z80_AW 16
`define BAR_W 9
`define BANK_W 5

// Master cycles per CPU enable
`define CE_DIV_NORMAL 3'd7
`define CE_DIV_TURBO1 3'd4
`define CE_DIV_TURBO2 3'd2

// Address regions and register pages
`define ROM_MAX_TOP 4'hA
`define CTRL_BUSREQ_PAGE 4'd1
`define CTRL_RESET_PAGE 4'd2
`define BANK_PAGE_HI 16'hA130
`define Z80_BANK_PAGE 8'h60

// 2 MB, counted in words like rom_size
`define ROM_BANK_THRESHOLD 23'h100000

`endif

//--- design/mbus_if.sv
// --------------------
// Main-bus interface
// Shared address, data, strobes and selects from the
// arbiter, read data and mappings back from the targets
// --------------------
`include "mbus_consts.svh"

interface mbus_if;
	logic [`MBUS_AW-1:0] addr;
	logic [`MBUS_DW-1:0] wdata;
	logic rnw;
	logic uds_n;
	logic lds_n;
	logic ram_sel;
	logic reg_sel;
	logic z80_bank_we;
	logic z80_bank_bit;
	logic [`MBUS_DW-1:0] ram_q;
	logic [`MBUS_DW-1:0] reg_q;
	logic [`MBUS_AW-1:0] rom_map_addr;
	logic [`BAR_W-1:0] bar;

	modport arbiter (
		output addr, wdata, rnw, uds_n, lds_n,
		output ram_sel, reg_sel, z80_bank_we, z80_bank_bit,
		input  ram_q, reg_q, rom_map_addr, bar
	);

	modport target (
		input  addr, wdata, rnw, uds_n, lds_n,
		input  ram_sel, reg_sel, z80_bank_we, z80_bank_bit,
		output ram_q, reg_q, rom_map_addr, bar
	);
endinterface

//--- design/mbus_pkg.sv
// --------------------
// Main-bus types
// Arbiter states, requester sources and turbo modes
// --------------------
package mbus_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELECT,
		ST_RAM_READ,
		ST_ROM_READ,
		ST_REG_READ,
		ST_Z80_BANK,
		ST_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		SRC_NONE,
		SRC_M68K,
		SRC_Z80
	} mbus_src_t;

	// CPU clock rate select
	typedef enum logic [1:0] {
		TURBO_NORMAL,
		TURBO_1,
		TURBO_2
	} turbo_t;

endpackage

//--- design/sys_regs.sv
// --------------------
// System registers
// Z80 bus request and reset at A11100 and A11200,
// ROM bank registers and mapper at A130xx,
// Z80 bank address register
// --------------------
`include "mbus_consts.svh"

module sys_regs (
	input  logic                MCLK,
	input  logic                reset,
	input  logic [`MBUS_AW-1:0] rom_size,
	output logic                z80_busreq_n,
	output logic                z80_reset_n,
	mbus_if.target              bus
);
	logic [`BANK_W-1:0] bank_reg [0:7];
	logic bank_mode;
	logic [3:0] page;
	logic ctrl_hit;
	logic bank_hit;
	logic wr_cycle;
	logic ctrl_bit;

	// Byte address bits 11..8
	assign page     = bus.addr[10:7];
	assign ctrl_hit = (bus.addr[22:11] == 12'hA11) && (bus.addr[6:0] == 7'd0);
	assign bank_hit = bus.addr[22:7] == `BANK_PAGE_HI;
	assign wr_cycle = bus.reg_sel && !bus.rnw;

	always_comb begin
		case (page)
			`CTRL_BUSREQ_PAGE: ctrl_bit = z80_busreq_n;
			`CTRL_RESET_PAGE:  ctrl_bit = z80_reset_n;
			default:           ctrl_bit = 1'b0;
		endcase
	end

	// Everything outside the control page reads zero
	assign bus.reg_q = ctrl_hit ? {7'd0, ctrl_bit, 8'd0} : '0;

	// SSF2 mapping, 512 KB pages picked by byte address 21..19
	assign bus.rom_map_addr = bank_mode ? {bank_reg[bus.addr[20:18]], bus.addr[17:0]}
		: bus.addr;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
			bank_mode    <= 1'b0;
			bus.bar      <= '0;
			for (int i = 0; i < 8; i++)
				bank_reg[i] <= `BANK_W'(i);
		end else begin
			if (wr_cycle && ctrl_hit && !bus.uds_n) begin
				if (page == `CTRL_BUSREQ_PAGE)
					z80_busreq_n <= ~bus.wdata[8];
				if (page == `CTRL_RESET_PAGE)
					z80_reset_n <= bus.wdata[8];
			end
			// Bank 0 is fixed, banking only on large ROMs
			if (wr_cycle && bank_hit && !(bus.uds_n && bus.lds_n)
				&& (rom_size > `ROM_BANK_THRESHOLD) && (bus.addr[2:0] != 3'd0)) begin
				bank_reg[bus.addr[2:0]] <= bus.wdata[`BANK_W-1:0];
				bank_mode <= 1'b1;
			end
			// Serial load, nine writes fill the register
			if (bus.z80_bank_we)
				bus.bar <= {bus.z80_bank_bit, bus.bar[`BAR_W-1:1]};
		end
	end
endmodule

//--- design/work_ram.sv
// --------------------
// 68000 work RAM
// 64 KB in two byte lanes, mirrored over E00000-FFFFFF,
// registered read
// --------------------
`include "mbus_consts.svh"

module work_ram (
	input  logic   MCLK,
	mbus_if.target bus
);
	logic [7:0] mem_hi [0:(1 << `WRAM_AW) - 1];
	logic [7:0] mem_lo [0:(1 << `WRAM_AW) - 1];
	logic [`WRAM_AW-1:0] idx;

	// Upper address bits ignored, so the 64 KB repeats
	assign idx = bus.addr[`WRAM_AW-1:0];

	always_ff @(posedge MCLK) begin
		if (bus.ram_sel) begin
			if (!bus.rnw && !bus.uds_n)
				mem_hi[idx] <= bus.wdata[15:8];
			if (!bus.rnw && !bus.lds_n)
				mem_lo[idx] <= bus.wdata[7:0];
			bus.ram_q <= {mem_hi[idx], mem_lo[idx]};
		end
	end
endmodule

//--- filelist.f
+incdir+design
design/mbus_pkg.sv
design/mbus_if.sv
design/clk_enable_gen.sv
design/mbus_arbiter.sv
design/work_ram.sv
design/sys_regs.sv
design/genesis_mbus.sv
test/tb_checks.sv
test/tb_genesis_mbus.sv

//--- test/tb_checks.sv
// --------------------
// Handshake and clock enable checker
// Acknowledge overlap and hold rules, cpu_ce period
// against the turbo rate picked at each pulse
// --------------------
module tb_checks (
	input logic             MCLK,
	input logic             reset,
	input logic             cpu_ce,
	input mbus_pkg::turbo_t turbo,
	input logic             m68k_req,
	input logic             m68k_ack,
	input logic             z80_req,
	input logic             z80_ack
);
	timeunit 1ns;
	timeprecision 1ps;
	import mbus_pkg::*;

	int err_count = 0;
	int gap;
	int exp_gap;
	bit have_prev;
	logic m68k_req_q, m68k_ack_q, z80_req_q, z80_ack_q;

	// Master cycles between enables for each turbo setting
	function automatic int ce_period(turbo_t t);
		case (t)
			TURBO_1: return 4;
			TURBO_2: return 2;
			default: return 7;
		endcase
	endfunction

	always @(posedge MCLK) begin
		if (reset) begin
			have_prev = 0;
			m68k_req_q = 0;
			m68k_ack_q = 0;
			z80_req_q = 0;
			z80_ack_q = 0;
		end else begin
			assert (!(m68k_ack && z80_ack)) else begin
				err_count++;
				$display("Error at %0t: both acknowledges high together", $time);
			end
			assert (!(m68k_ack_q && m68k_req_q && !m68k_ack)) else begin
				err_count++;
				$display("Error at %0t: 68000 acknowledge fell while request held", $time);
			end
			assert (!(m68k_ack && !m68k_req && !m68k_req_q)) else begin
				err_count++;
				$display("Error at %0t: 68000 acknowledge high without request", $time);
			end
			assert (!(z80_ack_q && z80_req_q && !z80_ack)) else begin
				err_count++;
				$display("Error at %0t: Z80 acknowledge fell while request held", $time);
			end
			assert (!(z80_ack && !z80_req && !z80_req_q)) else begin
				err_count++;
				$display("Error at %0t: Z80 acknowledge high without request", $time);
			end
			// Period checked pulse to pulse
			if (cpu_ce) begin
				if (have_prev)
					assert (gap == exp_gap) else begin
						err_count++;
						$display("FAILED t=%0t signal=cpu_ce_period got=%0d exp=%0d",
							$time, gap, exp_gap);
					end
				exp_gap = ce_period(turbo);
				gap = 1;
				have_prev = 1;
			end else begin
				gap++;
			end
			m68k_req_q = m68k_req;
			m68k_ack_q = m68k_ack;
			z80_req_q = z80_req;
			z80_ack_q = z80_ack;
		end
	end
endmodule

//--- test/tb_genesis_mbus.sv
// --------------------
// Main-bus testbench
// Drives both requester ports, models the cartridge ROM
// and checks work RAM, ROM mapping, control registers,
// the Z80 window and arbitration
// --------------------
`include "mbus_consts.svh"

module tb_genesis_mbus;
	timeunit 1ns;
	timeprecision 1ps;
	import mbus_pkg::*;

	localparam int TIMEOUT = 4000;

	logic MCLK = 1'b0;
	logic reset;
	turbo_t turbo;
	logic cpu_ce;
	logic m68k_req, m68k_rnw, m68k_ack;
	logic [`MBUS_AW-1:0] m68k_addr;
	logic [`MBUS_DW-1:0] m68k_wdata, m68k_rdata;
	logic [1:0] m68k_be;
	logic z80_req, z80_rnw, z80_ack;
	logic [`Z80_AW-1:0] z80_addr;
	logic [7:0] z80_wdata, z80_rdata;
	logic [`MBUS_AW-1:0] rom_size, rom_addr, rom_seen_addr;
	logic rom_req, rom_ack;
	logic [`MBUS_DW-1:0] rom_data;
	logic z80_busreq_n, z80_reset_n;

	int errors = 0;
	int cycles = 0;
	int rom_wait;
	bit rom_busy;
	logic [15:0] sb [int];

	always #20 MCLK = ~MCLK;

	genesis_mbus dut_i (.*);

	tb_checks chk_i (
		.MCLK(MCLK), .reset(reset), .cpu_ce(cpu_ce), .turbo(turbo),
		.m68k_req(m68k_req), .m68k_ack(m68k_ack), .z80_req(z80_req), .z80_ack(z80_ack)
	);

	// --------------------
	// ROM responder
	// --------------------
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack <= 1'b0;
			rom_busy = 0;
		end else if (!rom_busy && rom_req != rom_ack) begin
			rom_busy = 1;
			rom_wait = 1 + ($urandom % 8);
			rom_seen_addr = rom_addr;
		end else if (rom_busy) begin
			rom_wait--;
			if (rom_wait == 0) begin
				rom_data <= rom_seen_addr[15:0] ^ 16'h5A5A;
				rom_ack <= rom_req;
				rom_busy = 0;
			end
		end
	end

	always @(posedge MCLK) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: run still busy after %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAILED t=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	function automatic logic [15:0] merge_bytes(logic [15:0] old, logic [15:0] nw, logic [1:0] be);
		return {be[1] ? nw[15:8] : old[15:8], be[0] ? nw[7:0] : old[7:0]};
	endfunction

	task automatic m68k_access(input logic [22:0] addr, input logic [15:0] wdata,
		input logic rnw, input logic [1:0] be, input bit chk_lat,
		output logic [15:0] rdata, output time ack_t);
		int n;
		bit acc;
		n = 0;
		acc = 0;
		@(posedge MCLK);
		m68k_req <= 1'b1;
		m68k_addr <= addr;
		m68k_wdata <= wdata;
		m68k_rnw <= rnw;
		m68k_be <= be;
		do begin
			@(posedge MCLK);
			if (acc)
				n++;
			else if (cpu_ce)
				acc = 1;
		end while (!m68k_ack);
		rdata = m68k_rdata;
		ack_t = $time;
		if (chk_lat)
			check_value("m68k_ack_latency", n, 3);
		m68k_req <= 1'b0;
		@(posedge MCLK);
	endtask

	task automatic z80_access(input logic [15:0] addr, input logic [7:0] wdata,
		input logic rnw, input bit chk_lat, output logic [7:0] rdata, output time ack_t);
		int n;
		n = 0;
		@(posedge MCLK);
		z80_req <= 1'b1;
		z80_addr <= addr;
		z80_wdata <= wdata;
		z80_rnw <= rnw;
		@(posedge MCLK);
		while (!z80_ack) begin
			@(posedge MCLK);
			n++;
		end
		rdata = z80_rdata;
		ack_t = $time;
		if (chk_lat)
			check_value("z80_ack_latency", n, 3);
		z80_req <= 1'b0;
		@(posedge MCLK);
	endtask

	initial begin
		logic [22:0] addrs [8];
		logic [22:0] a;
		logic [15:0] d, rd;
		logic [7:0] zd;
		logic [1:0] be;
		time t_m, t_z;
		void'($urandom(32'h7436));
		reset = 1'b1;
		turbo = TURBO_NORMAL;
		m68k_req = 1'b0;
		m68k_addr = '0;
		m68k_wdata = '0;
		m68k_rnw = 1'b1;
		m68k_be = 2'b11;
		z80_req = 1'b0;
		z80_addr = '0;
		z80_wdata = '0;
		z80_rnw = 1'b1;
		rom_size = 23'h080000;
		rom_ack = 1'b0;
		rom_data = '0;
		repeat (2) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);

		// Reset defaults
		check_value("m68k_ack", m68k_ack, 0);
		check_value("z80_ack", z80_ack, 0);
		check_value("z80_busreq_n", z80_busreq_n, 1);
		check_value("z80_reset_n", z80_reset_n, 0);
		check_value("bar", dut_i.bus.bar, 0);
		check_value("bank_mode", dut_i.regs_i.bank_mode, 0);
		check_value("rom_req", rom_req, 0);
		check_value("cpu_ce", cpu_ce, 1);
		for (int i = 0; i < 8; i++)
			check_value("bank_reg", dut_i.regs_i.bank_reg[i], i);

		// Turbo rates, period checked by the checker
		turbo <= TURBO_1;
		repeat (20) @(posedge MCLK);
		turbo <= TURBO_2;
		repeat (12) @(posedge MCLK);
		turbo <= TURBO_NORMAL;
		repeat (20) @(posedge MCLK);

		// --------------------
		// Work RAM
		// --------------------
		for (int i = 0; i < 8; i++) begin
			addrs[i] = 23'h700000 | 23'($urandom & 32'h7FFF);
			d = 16'($urandom);
			m68k_access(addrs[i], d, 1'b0, 2'b11, 1, rd, t_m);
			sb[addrs[i][14:0]] = d;
		end
		for (int i = 0; i < 8; i++) begin
			d = 16'($urandom);
			be = 2'($urandom);
			m68k_access(addrs[i], d, 1'b0, be, 1, rd, t_m);
			sb[addrs[i][14:0]] = merge_bytes(sb[addrs[i][14:0]], d, be);
		end
		for (int i = 0; i < 8; i++) begin
			m68k_access(addrs[i], 16'h0, 1'b1, 2'b11, 1, rd, t_m);
			check_value("m68k_rdata", rd, sb[addrs[i][14:0]]);
			m68k_access(addrs[i] ^ 23'h0A8000, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
			check_value("m68k_rdata_mirror", rd, sb[addrs[i][14:0]]);
		end

		// --------------------
		// ROM reads, plain then banked
		// --------------------
		a = 23'h012345;
		m68k_access(a, 16'h0, 1'b1, 2'b11, 0, rd, t_m);
		check_value("rom_addr", rom_seen_addr, a);
		check_value("m68k_rdata", rd, a[15:0] ^ 16'h5A5A);
		m68k_access(23'h090000, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
		check_value("m68k_rdata_unmapped", rd, 0);
		rom_size <= 23'h200000;
		m68k_access(23'h509801, 16'h000C, 1'b0, 2'b01, 1, rd, t_m);
		a = 23'h040123;
		m68k_access(a, 16'h0, 1'b1, 2'b11, 0, rd, t_m);
		check_value("rom_addr", rom_seen_addr, {5'h0C, a[17:0]});
		check_value("m68k_rdata", rd, a[15:0] ^ 16'h5A5A);
		a = 23'h0C0010;
		m68k_access(a, 16'h0, 1'b1, 2'b11, 0, rd, t_m);
		check_value("rom_addr", rom_seen_addr, {5'd3, a[17:0]});

		// --------------------
		// Z80 control registers
		// --------------------
		m68k_access(23'h508880, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
		check_value("m68k_rdata_busreq", rd, 16'h0100);
		m68k_access(23'h508880, 16'h0100, 1'b0, 2'b10, 1, rd, t_m);
		check_value("z80_busreq_n", z80_busreq_n, 0);
		m68k_access(23'h508880, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
		check_value("m68k_rdata_busreq", rd, 16'h0000);
		m68k_access(23'h508900, 16'h0100, 1'b0, 2'b10, 1, rd, t_m);
		check_value("z80_reset_n", z80_reset_n, 1);
		m68k_access(23'h508900, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
		check_value("m68k_rdata_reset", rd, 16'h0100);

		// --------------------
		// Z80 window, bank 1C5 lands in work RAM
		// --------------------
		for (int i = 0; i < 9; i++)
			z80_access(16'h6000, {7'd0, 1'(9'h1C5 >> i)}, 1'b0, 1, zd, t_z);
		check_value("bar", dut_i.bus.bar, 9'h1C5);
		z80_access(16'h1234, 8'h0, 1'b1, 1, zd, t_z);
		check_value("z80_rdata_local", zd, 8'hFF);
		a = {9'h1C5, 14'h0008};
		m68k_access(a, 16'hABCD, 1'b0, 2'b11, 1, rd, t_m);
		z80_access(16'h8010, 8'h0, 1'b1, 1, zd, t_z);
		check_value("z80_rdata", zd, 8'hAB);
		z80_access(16'h8011, 8'h77, 1'b0, 1, zd, t_z);
		m68k_access(a, 16'h0, 1'b1, 2'b11, 1, rd, t_m);
		check_value("m68k_rdata", rd, 16'hAB77);

		// --------------------
		// Tie on an enable cycle
		// --------------------
		turbo <= TURBO_2;
		repeat (10) @(posedge MCLK);
		do
			@(posedge MCLK);
		while (!cpu_ce);
		fork
			m68k_access(a, 16'h0, 1'b1, 2'b11, 0, rd, t_m);
			z80_access(16'h8011, 8'h0, 1'b1, 0, zd, t_z);
		join
		check_value("m68k_rdata", rd, 16'hAB77);
		check_value("z80_rdata", zd, 8'h77);
		assert (t_m < t_z) else begin
			errors++;
			$display("Error at %0t: Z80 acknowledged before the 68000 on a tie", $time);
		end
		repeat (4) @(posedge MCLK);

		$display("Errors: %0d sequence, %0d protocol", errors, chk_i.err_count);
		if (errors + chk_i.err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule
